//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module l2cache_tb -o l2cache_sim
	out=$$(./obj_dir/l2cache_sim); echo "$$out"; echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- dv/l2cache_sva.sv
`timescale 1ns/1ps

module l2cache_sva import l2_types_pkg::*; (
	input logic clk,
	input logic rst,
	input l2_state_t state,
	input logic cache_resp,
	input logic mem_read,
	input logic mem_write,
	input logic mem_resp
);

	assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
		else $error("mem_read and mem_write high in the same cycle");

	// the refilled line must hit on the retry
	assert property (@(posedge clk) disable iff (rst)
		state == s_allocate && mem_resp |=> cache_resp && state == s_check)
		else $error("access after allocate did not complete as a hit");

	assert property (@(posedge clk) disable iff (rst) mem_read && !mem_resp |=> mem_read)
		else $error("mem_read dropped before mem_resp");

	assert property (@(posedge clk) disable iff (rst) mem_write && !mem_resp |=> mem_write)
		else $error("mem_write dropped before mem_resp");

endmodule : l2cache_sva

bind l2cache_control l2cache_sva sva (
	.clk,
	.rst,
	.state,
	.cache_resp,
	.mem_read,
	.mem_write,
	.mem_resp
);

//--- dv/l2cache_tb.sv
`timescale 1ns/1ps

module l2cache_tb import l2_types_pkg::*; ();

	localparam int num_lines = 4096; // 64K bytes of lines
	localparam int num_random = 300;
	localparam int lru_rounds = 4;
	localparam int total_ops = num_random + 1 + lru_rounds * 13;

	logic clk;
	logic rst;
	logic cache_read;
	logic cache_write;
	l2_addr_t cache_address;
	l2_line_t cache_wdata;
	l2_line_t cache_rdata;
	logic cache_resp;
	logic mem_read;
	logic mem_write;
	lc3b_word mem_address;
	l2_line_t mem_wdata;
	l2_line_t mem_rdata;
	logic mem_resp;
	integer seed = 86;

	l2_line_t mem [num_lines];
	l2_line_t shadow [num_lines]; // latest value of every line
	logic [tag_width-1:0] m_tag [num_sets][num_ways];
	logic m_valid [num_sets][num_ways];
	logic m_dirty [num_sets][num_ways];
	l2_line_t m_data [num_sets][num_ways];
	way_t m_order [num_sets][num_ways]; // slot 0 most recent

	l2cache uut (
		.clk,
		.rst,
		.cache_read,
		.cache_write,
		.cache_address,
		.cache_wdata,
		.cache_rdata,
		.cache_resp,
		.mem_read,
		.mem_write,
		.mem_address,
		.mem_wdata,
		.mem_rdata,
		.mem_resp
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// each word holds its own byte address, scrambled
	function automatic l2_line_t fill_line(input int line);
		l2_line_t v;
		for (int k = 0; k < 8; k++) begin
			v[k*16 +: 16] = lc3b_word'(line * 16 + k * 2) ^ 16'ha5c3;
		end
		return v;
	endfunction

	function automatic l2_addr_t make_addr(input int tag, input int index, input int offset);
		l2_addr_t a;
		a.f.tag = tag_width'(tag);
		a.f.index = index_width'(index);
		a.f.offset = 4'(offset);
		return a;
	endfunction

	function automatic l2_line_t rand_line();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic touch_lru(input int idx, input way_t w);
		int pos;
		pos = num_ways - 1;
		for (int p = 0; p < num_ways; p++) begin
			if (m_order[idx][p] == w) begin
				pos = p;
			end
		end
		for (int p = pos; p > 0; p--) begin
			m_order[idx][p] = m_order[idx][p-1];
		end
		m_order[idx][0] = w;
	endtask

	// memory model, answers after 1 to 4 cycles
	initial begin : mem_responder
		int lat;
		int line;
		mem_resp = 1'b0;
		mem_rdata = '0;
		for (int i = 0; i < num_lines; i++) begin
			mem[i] = fill_line(i);
		end
		forever begin
			@(negedge clk);
			if (mem_read || mem_write) begin
				lat = 1 + int'($unsigned($random(seed)) % 4);
				repeat (lat) @(posedge clk);
				#1;
				line = int'(mem_address[15:4]);
				if (mem_write) begin
					mem[line] = mem_wdata;
				end else begin
					mem_rdata = mem[line];
				end
				mem_resp = 1'b1;
				@(posedge clk);
				#1;
				mem_resp = 1'b0;
			end
		end
	end

	// want: 0 any, 1 must hit, 2 must miss
	task automatic do_access(input logic wr, input l2_addr_t addr, input l2_line_t wdata,
			input int want);
		int idx;
		int line;
		int cycles;
		int rd_cnt;
		int wr_cnt;
		logic pred_hit;
		logic mem_seen;
		logic done;
		logic exp_wb;
		way_t way;
		way_t victim;
		lc3b_word rd_addr;
		lc3b_word wr_addr;
		lc3b_word exp_wb_addr;
		l2_line_t wr_data;
		l2_line_t exp_wb_data;

		idx = int'(addr.f.index);
		line = int'(addr.raw[15:4]);
		pred_hit = 1'b0;
		way = '0;
		for (int w = 0; w < num_ways; w++) begin
			if (m_valid[idx][w] && m_tag[idx][w] == addr.f.tag) begin
				pred_hit = 1'b1;
				way = way_t'(w);
			end
		end
		victim = m_order[idx][num_ways-1];
		exp_wb = !pred_hit && m_valid[idx][victim] && m_dirty[idx][victim];
		exp_wb_addr = {m_tag[idx][victim], addr.f.index, 4'h0};
		exp_wb_data = m_data[idx][victim];
		assert (want != 1 || pred_hit) else begin
			$display("expected a hit but the line should have been evicted");
			abort_run();
		end
		assert (want != 2 || !pred_hit) else begin
			$display("expected a miss but the line should still be cached");
			abort_run();
		end

		rd_cnt = 0;
		wr_cnt = 0;
		mem_seen = 1'b0;
		done = 1'b0;
		cycles = 0;
		rd_addr = '0;
		wr_addr = '0;
		wr_data = '0;
		cache_read = !wr;
		cache_write = wr;
		cache_address = addr;
		cache_wdata = wdata;
		while (!done) begin
			@(negedge clk);
			cycles++;
			if (mem_read || mem_write) mem_seen = 1'b1;
			if (mem_resp && mem_read) begin
				rd_cnt++;
				rd_addr = mem_address;
			end
			if (mem_resp && mem_write) begin
				assert (rd_cnt == 0) else begin
					$display("write-back came after the allocate read");
					abort_run();
				end
				wr_cnt++;
				wr_addr = mem_address;
				wr_data = mem_wdata;
			end
			if (cache_resp) begin
				done = 1'b1;
			end else if (cycles > 50) begin
				$display("no cache_resp within 50 cycles at address %h", addr.raw);
				abort_run();
			end
		end

		if (!wr) begin
			assert (cache_rdata == shadow[line]) else begin
				$display("ERROR cache_rdata 0x%h expected 0x%h", cache_rdata, shadow[line]);
				abort_run();
			end
		end
		if (pred_hit) begin
			assert (!mem_seen && cycles == 1) else begin
				$display("hit at %h took %0d cycles or touched memory", addr.raw, cycles);
				abort_run();
			end
		end else begin
			assert (rd_cnt == 1) else begin
				$display("ERROR mem_read count 0x%h expected 0x1", rd_cnt);
				abort_run();
			end
			assert (rd_addr == {addr.f.tag, addr.f.index, 4'h0}) else begin
				$display("ERROR mem_address 0x%h expected 0x%h", rd_addr,
					{addr.f.tag, addr.f.index, 4'h0});
				abort_run();
			end
			assert (wr_cnt == (exp_wb ? 1 : 0)) else begin
				$display("ERROR mem_write count 0x%h expected 0x%h", wr_cnt, exp_wb);
				abort_run();
			end
			if (exp_wb) begin
				assert (wr_addr == exp_wb_addr && wr_data == exp_wb_data) else begin
					$display("ERROR mem_address 0x%h mem_wdata 0x%h expected 0x%h 0x%h",
						wr_addr, wr_data, exp_wb_addr, exp_wb_data);
					abort_run();
				end
			end
			way = victim; // allocate into the lru way, clean
			m_tag[idx][way] = addr.f.tag;
			m_valid[idx][way] = 1'b1;
			m_dirty[idx][way] = 1'b0;
			m_data[idx][way] = shadow[line];
		end
		if (wr) begin
			m_data[idx][way] = wdata;
			m_dirty[idx][way] = 1'b1;
			shadow[line] = wdata;
		end
		touch_lru(idx, way);
		@(posedge clk);
		#1;
		cache_read = 1'b0;
		cache_write = 1'b0;
	endtask

	initial begin : watchdog
		repeat (total_ops * 40) @(posedge clk);
		$display("watchdog expired after %0d cycles", total_ops * 40);
		abort_run();
	end

	initial begin : run_tests
		int perm [4];
		int j;
		int tmp;
		int base;
		rst = 1'b1;
		cache_read = 1'b0;
		cache_write = 1'b0;
		cache_address = '0;
		cache_wdata = '0;
		for (int i = 0; i < num_lines; i++) begin
			shadow[i] = fill_line(i);
		end
		for (int s = 0; s < num_sets; s++) begin
			for (int w = 0; w < num_ways; w++) begin
				m_tag[s][w] = '0;
				m_valid[s][w] = 1'b0;
				m_dirty[s][w] = 1'b0;
				m_data[s][w] = '0;
				m_order[s][w] = way_t'(num_ways - 1 - w);
			end
		end
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		assert (!cache_resp && !mem_read && !mem_write) else begin
			$display("control output active right after reset");
			abort_run();
		end
		@(posedge clk);
		#1;

		do_access(1'b0, make_addr(9, 3, 0), '0, 2);
		// few tags over few sets, lots of evictions
		for (int n = 0; n < num_random; n++) begin
			do_access(($unsigned($random(seed)) % 3) == 0,
				make_addr(8 + int'($unsigned($random(seed)) % 6),
					3 + int'($unsigned($random(seed)) % 3) * 7,
					int'($unsigned($random(seed)) % 16)),
				rand_line(), 0);
		end

		for (int r = 0; r < lru_rounds; r++) begin
			base = 40 + r * 5;
			for (int k = 0; k < 4; k++) begin
				perm[k] = k;
				do_access(1'b0, make_addr(base + k, 20 + r, 0), '0, 2);
			end
			for (int k = 3; k > 0; k--) begin
				j = int'($unsigned($random(seed)) % (k + 1));
				tmp = perm[k];
				perm[k] = perm[j];
				perm[j] = tmp;
			end
			for (int k = 0; k < 4; k++) begin
				do_access(($unsigned($random(seed)) % 2) == 0,
					make_addr(base + perm[k], 20 + r, 0), rand_line(), 1);
			end
			do_access(1'b0, make_addr(base + 4, 20 + r, 0), '0, 2); // evicts perm[0]
			for (int k = 1; k < 4; k++) begin
				do_access(1'b0, make_addr(base + perm[k], 20 + r, 0), '0, 1);
			end
			do_access(1'b0, make_addr(base + perm[0], 20 + r, 0), '0, 2);
		end

		$display("All checks passed");
		$finish;
	end

endmodule : l2cache_tb

//--- src.f
verilog/l2_types_pkg.sv
verilog/l2_ctrl_if.sv
verilog/l2_array.sv
verilog/lru_stack.sv
verilog/l2cache_datapath.sv
verilog/l2cache_control.sv
verilog/l2cache.sv
dv/l2cache_sva.sv
dv/l2cache_tb.sv

//--- verilog/l2_array.sv
`timescale 1ns/1ps

module l2_array import l2_types_pkg::*; #(
	parameter int width = 128
) (
	input logic clk,
	input logic rst,
	input logic write,
	input logic [index_width-1:0] index,
	input logic [width-1:0] datain,
	output logic [width-1:0] dataout
);

	logic [width-1:0] entries [num_sets];

	assign dataout = entries[index]; // async read

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_sets; i++) begin
				entries[i] <= '0;
			end
		end else if (write) begin
			entries[index] <= datain;
		end
	end

endmodule : l2_array

//--- verilog/l2_ctrl_if.sv
`timescale 1ns/1ps

interface l2_ctrl_if import l2_types_pkg::*; ();

	// strobes from control, one bit per way
	logic [num_ways-1:0] load_data; // data, tag and valid
	logic [num_ways-1:0] load_dirty;
	logic dirty_in;
	logic load_lru;
	logic fill_sel; // allocate: memory line in, request address out

	// status back from the datapath
	logic hit;
	way_t hit_way;
	way_t lru_way; // victim of the indexed set
	logic victim_dirty;

	modport ctrl (
		output load_data, load_dirty, dirty_in, load_lru, fill_sel,
		input hit, hit_way, lru_way, victim_dirty
	);

	modport dp (
		input load_data, load_dirty, dirty_in, load_lru, fill_sel,
		output hit, hit_way, lru_way, victim_dirty
	);

endinterface : l2_ctrl_if

//--- verilog/l2_types_pkg.sv
package l2_types_pkg;

	// cache geometry
	localparam int tag_width = 7;
	localparam int index_width = 5;
	localparam int offset_width = 4;
	localparam int num_ways = 4;
	localparam int num_sets = 1 << index_width;

	typedef logic [15:0] lc3b_word;
	typedef logic [127:0] l2_line_t;
	typedef logic [$clog2(num_ways)-1:0] way_t;

	typedef struct packed {
		logic [tag_width-1:0] tag;
		logic [index_width-1:0] index;
		logic [offset_width-1:0] offset; // byte within line
	} l2_addr_fields_t;

	// same word seen raw or split into fields
	typedef union packed {
		lc3b_word raw;
		l2_addr_fields_t f;
	} l2_addr_t;

	typedef enum logic [1:0] {
		s_check,
		s_writeback,
		s_allocate
	} l2_state_t;

endpackage : l2_types_pkg

//--- verilog/l2cache.sv
`timescale 1ns/1ps

module l2cache import l2_types_pkg::*; (
	input logic clk,
	input logic rst,

	// upstream, whole lines
	input logic cache_read,
	input logic cache_write,
	input l2_addr_t cache_address,
	input l2_line_t cache_wdata,
	output l2_line_t cache_rdata,
	output logic cache_resp,

	// memory side
	output logic mem_read,
	output logic mem_write,
	output lc3b_word mem_address,
	output l2_line_t mem_wdata,
	input l2_line_t mem_rdata,
	input logic mem_resp
);

	l2_ctrl_if ctl ();

	l2cache_control control (
		.clk,
		.rst,
		.ctl(ctl.ctrl),
		.cache_read,
		.cache_write,
		.mem_resp,
		.cache_resp,
		.mem_read,
		.mem_write
	);

	l2cache_datapath datapath (
		.clk,
		.rst,
		.ctl(ctl.dp),
		.cache_address,
		.cache_wdata,
		.mem_rdata,
		.cache_rdata,
		.mem_address,
		.mem_wdata
	);

endmodule : l2cache

//--- verilog/l2cache_control.sv
`timescale 1ns/1ps

module l2cache_control import l2_types_pkg::*; (
	input logic clk,
	input logic rst,
	l2_ctrl_if.ctrl ctl,
	input logic cache_read,
	input logic cache_write,
	input logic mem_resp,
	output logic cache_resp,
	output logic mem_read,
	output logic mem_write
);

	l2_state_t state;
	l2_state_t next_state;
	logic request;
	logic [num_ways-1:0] hit_sel;
	logic [num_ways-1:0] lru_sel;

	assign request = cache_read || cache_write;

	// one-hot way strobes
	always_comb begin
		hit_sel = '0;
		hit_sel[ctl.hit_way] = 1'b1;
		lru_sel = '0;
		lru_sel[ctl.lru_way] = 1'b1;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= s_check;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			s_check: begin
				if (request && !ctl.hit) begin
					// dirty victim goes out first
					next_state = ctl.victim_dirty ? s_writeback : s_allocate;
				end
			end
			s_writeback: begin
				if (mem_resp) begin
					next_state = s_allocate;
				end
			end
			s_allocate: begin
				if (mem_resp) begin
					next_state = s_check; // retry as a hit
				end
			end
			default: begin
				next_state = s_check;
			end
		endcase
	end

	// mem_read and mem_write from state only
	always_comb begin
		cache_resp = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		ctl.load_data = '0;
		ctl.load_dirty = '0;
		ctl.dirty_in = 1'b0;
		ctl.load_lru = 1'b0;
		ctl.fill_sel = 1'b0;
		case (state)
			s_check: begin
				if (request && ctl.hit) begin
					cache_resp = 1'b1;
					ctl.load_lru = 1'b1;
					if (cache_write) begin
						ctl.load_data = hit_sel;
						ctl.load_dirty = hit_sel;
						ctl.dirty_in = 1'b1;
					end
				end
			end
			s_writeback: begin
				mem_write = 1'b1; // victim address selected
			end
			s_allocate: begin
				mem_read = 1'b1;
				ctl.fill_sel = 1'b1;
				if (mem_resp) begin
					// fill victim way, clean
					ctl.load_data = lru_sel;
					ctl.load_dirty = lru_sel;
				end
			end
			default: begin
				cache_resp = 1'b0;
			end
		endcase
	end

endmodule : l2cache_control

//--- verilog/l2cache_datapath.sv
`timescale 1ns/1ps

module l2cache_datapath import l2_types_pkg::*; (
	input logic clk,
	input logic rst,
	l2_ctrl_if.dp ctl,
	input l2_addr_t cache_address,
	input l2_line_t cache_wdata,
	input l2_line_t mem_rdata,
	output l2_line_t cache_rdata,
	output lc3b_word mem_address,
	output l2_line_t mem_wdata
);

	l2_line_t data_in;
	l2_line_t data_out [num_ways];
	logic [tag_width-1:0] tag_out [num_ways];
	logic [num_ways-1:0] valid_out;
	logic [num_ways-1:0] dirty_out;
	logic [num_ways-1:0] way_hit;
	way_t hit_way;
	way_t lru_way;
	l2_addr_t victim_addr;
	l2_addr_t fetch_addr;

	// fill from memory on allocate, else upstream line
	assign data_in = ctl.fill_sel ? mem_rdata : cache_wdata;

	for (genvar w = 0; w < num_ways; w++) begin : g_way
		l2_array #(.width($bits(l2_line_t))) data_array (
			.clk,
			.rst,
			.write(ctl.load_data[w]),
			.index(cache_address.f.index),
			.datain(data_in),
			.dataout(data_out[w])
		);

		l2_array #(.width(tag_width)) tag_array (
			.clk,
			.rst,
			.write(ctl.load_data[w]),
			.index(cache_address.f.index),
			.datain(cache_address.f.tag),
			.dataout(tag_out[w])
		);

		l2_array #(.width(1)) valid_array (
			.clk,
			.rst,
			.write(ctl.load_data[w]),
			.index(cache_address.f.index),
			.datain(1'b1),
			.dataout(valid_out[w])
		);

		l2_array #(.width(1)) dirty_array (
			.clk,
			.rst,
			.write(ctl.load_dirty[w]),
			.index(cache_address.f.index),
			.datain(ctl.dirty_in),
			.dataout(dirty_out[w])
		);

		assign way_hit[w] = valid_out[w] && (tag_out[w] == cache_address.f.tag);
	end

	lru_stack lru (
		.clk,
		.rst,
		.index(cache_address.f.index),
		.load_lru(ctl.load_lru),
		.access_way(hit_way),
		.lru_way(lru_way)
	);

	// at most one way matches
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < num_ways; w++) begin
			if (way_hit[w]) begin
				hit_way = way_t'(w);
			end
		end
	end

	assign ctl.hit = |way_hit;
	assign ctl.hit_way = hit_way;
	assign ctl.lru_way = lru_way;
	assign ctl.victim_dirty = dirty_out[lru_way];

	assign cache_rdata = data_out[hit_way];
	assign mem_wdata = data_out[lru_way]; // victim line

	always_comb begin
		victim_addr.f.tag = tag_out[lru_way];
		victim_addr.f.index = cache_address.f.index;
		victim_addr.f.offset = '0;
		fetch_addr = cache_address;
		fetch_addr.f.offset = '0; // line aligned
	end

	assign mem_address = ctl.fill_sel ? fetch_addr.raw : victim_addr.raw;

endmodule : l2cache_datapath

//--- verilog/lru_stack.sv
`timescale 1ns/1ps

module lru_stack import l2_types_pkg::*; (
	input logic clk,
	input logic rst,
	input logic [index_width-1:0] index,
	input logic load_lru,
	input way_t access_way,
	output way_t lru_way
);

	// position 0 is most recent, top of stack
	way_t [num_ways-1:0] order [num_sets];
	way_t [num_ways-1:0] cur_order;
	way_t [num_ways-1:0] new_order;
	way_t hit_pos;

	assign cur_order = order[index];
	assign lru_way = cur_order[num_ways-1]; // bottom entry

	always_comb begin
		hit_pos = '0;
		for (int i = 0; i < num_ways; i++) begin
			if (cur_order[i] == access_way) begin
				hit_pos = way_t'(i);
			end
		end
		new_order[0] = access_way;
		// entries above the old slot slide down one
		for (int i = 1; i < num_ways; i++) begin
			new_order[i] = (i <= hit_pos) ? cur_order[i-1] : cur_order[i];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int s = 0; s < num_sets; s++) begin
				order[s] <= {2'd0, 2'd1, 2'd2, 2'd3}; // way 0 at bottom
			end
		end else if (load_lru) begin
			order[index] <= new_order;
		end
	end

endmodule : lru_stack
